// ==== hdl/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int XLEN     = 32;
    localparam int SQ_DEPTH = 4;
    localparam int SQ_IDX_W = 2;
    localparam int ROB_W    = 5;
    localparam int PHYS_W   = 6;

    typedef logic [XLEN-1:0]     word_t;
    typedef logic [ROB_W-1:0]    rob_idx_t;
    typedef logic [PHYS_W-1:0]   prd_t;
    typedef logic [SQ_IDX_W-1:0] sq_idx_t;
    typedef logic [3:0]          strb_t;

    typedef enum logic [1:0] {
        MSZ_B = 2'd0,
        MSZ_H = 2'd1,
        MSZ_W = 2'd2
    } mem_size_e;

    // Bytes of a word touched by an access
    function automatic strb_t byte_mask(input mem_size_e size, input logic [1:0] addr_lo);
        strb_t m;
        case (size)
            MSZ_B:   m = 4'b0001 << addr_lo;
            MSZ_H:   m = 4'b0011 << {addr_lo[1], 1'b0};
            MSZ_W:   m = 4'b1111;
            default: m = 4'b0000;
        endcase
        return m;
    endfunction

    // Moves store data onto the byte lanes it writes
    function automatic word_t lane_align(input word_t data, input mem_size_e size,
                                         input logic [1:0] addr_lo);
        word_t w;
        case (size)
            MSZ_B:   w = {24'b0, data[7:0]} << {addr_lo, 3'b000};
            MSZ_H:   w = {16'b0, data[15:0]} << {addr_lo[1], 4'b0000};
            default: w = data;
        endcase
        return w;
    endfunction

endpackage

`default_nettype wire

// ==== hdl/store_queue.sv ====
`default_nettype none

module store_queue (
    input  logic                clk,
    input  logic                rst_n,
    // Allocate
    input  logic                alloc_valid,
    input  lsu_pkg::rob_idx_t   alloc_rob_idx,
    input  lsu_pkg::mem_size_e  alloc_size,
    output logic                alloc_ready,
    // Store execute
    input  logic                exe_st_valid,
    input  lsu_pkg::rob_idx_t   exe_st_rob_idx,
    input  lsu_pkg::word_t      exe_st_base,
    input  lsu_pkg::word_t      exe_st_imm,
    input  lsu_pkg::word_t      exe_st_data,
    // Commit
    input  logic                commit_valid,
    input  lsu_pkg::rob_idx_t   commit_rob_idx,
    // Memory store port
    output logic                mem_st_valid,
    input  logic                mem_st_ready,
    output lsu_pkg::word_t      mem_st_addr,
    output lsu_pkg::word_t      mem_st_data,
    output lsu_pkg::strb_t      mem_st_strb,
    // Entry view for the forwarding scan
    output logic                sq_valid    [lsu_pkg::SQ_DEPTH],
    output logic                sq_addr_rdy [lsu_pkg::SQ_DEPTH],
    output lsu_pkg::rob_idx_t   sq_rob_idx  [lsu_pkg::SQ_DEPTH],
    output lsu_pkg::word_t      sq_addr     [lsu_pkg::SQ_DEPTH],
    output lsu_pkg::word_t      sq_data     [lsu_pkg::SQ_DEPTH],
    output lsu_pkg::strb_t      sq_strb     [lsu_pkg::SQ_DEPTH],
    output lsu_pkg::sq_idx_t    sq_head
);
    import lsu_pkg::*;

    logic            committed [SQ_DEPTH];
    mem_size_e       sq_size   [SQ_DEPTH];
    sq_idx_t         tail;
    logic [SQ_IDX_W:0] count;

    word_t st_addr;
    logic  alloc_fire;
    logic  drain_fire;

    assign st_addr     = exe_st_base + exe_st_imm;
    assign alloc_ready = (count != SQ_DEPTH);
    assign alloc_fire  = alloc_valid && alloc_ready;
    assign drain_fire  = mem_st_valid && mem_st_ready;

    // ====================
    // Control state
    // ====================
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                sq_valid[i]    <= 1'b0;
                sq_addr_rdy[i] <= 1'b0;
                committed[i]   <= 1'b0;
            end
            sq_head <= '0;
            tail    <= '0;
            count   <= '0;
        end else begin
            for (int i = 0; i < SQ_DEPTH; i++) begin
                if (exe_st_valid && sq_valid[i] && sq_rob_idx[i] == exe_st_rob_idx) begin
                    sq_addr_rdy[i] <= 1'b1;
                end
                if (commit_valid && sq_valid[i] && sq_rob_idx[i] == commit_rob_idx) begin
                    committed[i] <= 1'b1;
                end
            end

            // New entry starts unfilled and uncommitted
            if (alloc_fire) begin
                sq_valid[tail]    <= 1'b1;
                sq_addr_rdy[tail] <= 1'b0;
                committed[tail]   <= 1'b0;
                tail              <= tail + 1'b1;
            end

            if (drain_fire) begin
                sq_valid[sq_head] <= 1'b0;
                sq_head           <= sq_head + 1'b1;
            end

            case ({alloc_fire, drain_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // ====================
    // Entry payload
    // ====================
    always_ff @(posedge clk) begin
        if (alloc_fire) begin
            sq_rob_idx[tail] <= alloc_rob_idx;
            sq_size[tail]    <= alloc_size;
        end
        // Execute fills the entry holding the same ROB index
        for (int i = 0; i < SQ_DEPTH; i++) begin
            if (exe_st_valid && sq_valid[i] && sq_rob_idx[i] == exe_st_rob_idx) begin
                sq_addr[i] <= st_addr;
                sq_data[i] <= lane_align(exe_st_data, sq_size[i], st_addr[1:0]);
                sq_strb[i] <= byte_mask(sq_size[i], st_addr[1:0]);
            end
        end
    end

    // Head drains once committed and filled
    assign mem_st_valid = sq_valid[sq_head] && committed[sq_head] && sq_addr_rdy[sq_head];
    assign mem_st_addr  = {sq_addr[sq_head][XLEN-1:2], 2'b00};
    assign mem_st_data  = sq_data[sq_head];
    assign mem_st_strb  = sq_strb[sq_head];

endmodule

`default_nettype wire

// ==== hdl/store_forward.sv ====
`default_nettype none

module store_forward (
    input  logic               sq_valid    [lsu_pkg::SQ_DEPTH],
    input  logic               sq_addr_rdy [lsu_pkg::SQ_DEPTH],
    input  lsu_pkg::rob_idx_t  sq_rob_idx  [lsu_pkg::SQ_DEPTH],
    input  lsu_pkg::word_t     sq_addr     [lsu_pkg::SQ_DEPTH],
    input  lsu_pkg::word_t     sq_data     [lsu_pkg::SQ_DEPTH],
    input  lsu_pkg::strb_t     sq_strb     [lsu_pkg::SQ_DEPTH],
    input  lsu_pkg::sq_idx_t   sq_head,
    input  lsu_pkg::rob_idx_t  ld_rob_idx,
    input  lsu_pkg::word_t     ld_addr,
    input  lsu_pkg::mem_size_e ld_size,
    output logic               fwd_stall,
    output logic               fwd_hit,
    output lsu_pkg::word_t     fwd_data
);
    import lsu_pkg::*;

    strb_t ld_mask;
    logic  addr_missing;
    logic  match;
    strb_t match_strb;
    logic  covered;

    assign ld_mask = byte_mask(ld_size, ld_addr[1:0]);

    // Oldest to youngest, so the last overlap found is the youngest
    always_comb begin : scan
        sq_idx_t idx;
        logic    older;
        addr_missing = 1'b0;
        match        = 1'b0;
        match_strb   = '0;
        fwd_data     = '0;
        for (int k = 0; k < SQ_DEPTH; k++) begin
            idx   = sq_head + sq_idx_t'(k);
            older = sq_valid[idx] && (sq_rob_idx[idx] < ld_rob_idx);
            if (older && !sq_addr_rdy[idx]) begin
                addr_missing = 1'b1;
            end
            if (older && sq_addr_rdy[idx]
                    && sq_addr[idx][XLEN-1:2] == ld_addr[XLEN-1:2]
                    && |(sq_strb[idx] & ld_mask)) begin
                match      = 1'b1;
                match_strb = sq_strb[idx];
                fwd_data   = sq_data[idx];
            end
        end
    end

    assign covered = ((match_strb & ld_mask) == ld_mask);

    // Partial cover waits for the store to drain
    assign fwd_stall = addr_missing || (match && !covered);
    assign fwd_hit   = match && covered && !addr_missing;

endmodule

`default_nettype wire

// ==== hdl/load_align.sv ====
`default_nettype none

module load_align (
    input  lsu_pkg::word_t     word,
    input  logic [1:0]         addr_lo,
    input  lsu_pkg::mem_size_e size,
    input  logic               is_unsigned,
    output lsu_pkg::word_t     result
);
    import lsu_pkg::*;

    logic [7:0]  b;
    logic [15:0] h;

    assign b = word[{addr_lo, 3'b000} +: 8];
    assign h = word[{addr_lo[1], 4'b0000} +: 16];

    always_comb begin
        case (size)
            MSZ_B:   result = is_unsigned ? {24'b0, b} : {{24{b[7]}}, b};
            MSZ_H:   result = is_unsigned ? {16'b0, h} : {{16{h[15]}}, h};
            default: result = word;
        endcase
    end

endmodule

`default_nettype wire

// ==== hdl/load_pipe.sv ====
`default_nettype none

module load_pipe (
    input  logic               clk,
    input  logic               rst_n,
    // Load request
    input  logic               ld_valid,
    output logic               ld_ready,
    input  lsu_pkg::rob_idx_t  ld_rob_idx,
    input  lsu_pkg::prd_t      ld_prd,
    input  lsu_pkg::word_t     ld_base,
    input  lsu_pkg::word_t     ld_imm,
    input  lsu_pkg::mem_size_e ld_size,
    input  logic               ld_unsigned,
    output lsu_pkg::word_t     ld_addr,
    // Forwarding result
    input  logic               fwd_stall,
    input  logic               fwd_hit,
    input  lsu_pkg::word_t     fwd_data,
    // Memory load port
    output logic               mem_ld_valid,
    input  logic               mem_ld_ready,
    output lsu_pkg::word_t     mem_ld_addr,
    input  logic               mem_ld_resp_valid,
    input  lsu_pkg::word_t     mem_ld_resp_data,
    // Writeback
    output logic               wb_valid,
    input  logic               wb_ready,
    output lsu_pkg::rob_idx_t  wb_rob_idx,
    output lsu_pkg::prd_t      wb_prd,
    output lsu_pkg::word_t     wb_data
);
    import lsu_pkg::*;

    logic      busy;
    word_t     addr_q;
    mem_size_e size_q;
    logic      unsigned_q;
    rob_idx_t  rob_q;
    prd_t      prd_q;

    logic  ld_fire;
    logic  issue_fire;
    logic  resp_fire;
    word_t fwd_result;
    word_t mem_result;

    assign ld_addr    = ld_base + ld_imm;
    assign ld_ready   = !fwd_stall && !mem_ld_valid && !busy && !wb_valid;
    assign ld_fire    = ld_valid && ld_ready;
    assign issue_fire = mem_ld_valid && mem_ld_ready;
    assign resp_fire  = busy && mem_ld_resp_valid;

    assign mem_ld_addr = {addr_q[XLEN-1:2], 2'b00};

    load_align u_fwd_align (
        .word        (fwd_data),
        .addr_lo     (ld_addr[1:0]),
        .size        (ld_size),
        .is_unsigned (ld_unsigned),
        .result      (fwd_result)
    );

    load_align u_mem_align (
        .word        (mem_ld_resp_data),
        .addr_lo     (addr_q[1:0]),
        .size        (size_q),
        .is_unsigned (unsigned_q),
        .result      (mem_result)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_ld_valid <= 1'b0;
            busy         <= 1'b0;
            wb_valid     <= 1'b0;
        end else begin
            // Missed the queue, go to memory
            if (ld_fire && !fwd_hit) begin
                mem_ld_valid <= 1'b1;
            end else if (issue_fire) begin
                mem_ld_valid <= 1'b0;
            end
            if (issue_fire) begin
                busy <= 1'b1;
            end else if (resp_fire) begin
                busy <= 1'b0;
            end
            if ((ld_fire && fwd_hit) || resp_fire) begin
                wb_valid <= 1'b1;
            end else if (wb_ready) begin
                wb_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ld_fire) begin
            addr_q     <= ld_addr;
            size_q     <= ld_size;
            unsigned_q <= ld_unsigned;
            rob_q      <= ld_rob_idx;
            prd_q      <= ld_prd;
        end
        // Writeback buffer is free whenever either source fills it
        if (ld_fire && fwd_hit) begin
            wb_rob_idx <= ld_rob_idx;
            wb_prd     <= ld_prd;
            wb_data    <= fwd_result;
        end else if (resp_fire) begin
            wb_rob_idx <= rob_q;
            wb_prd     <= prd_q;
            wb_data    <= mem_result;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/lsu_top.sv ====
`default_nettype none

module lsu_top (
    input  logic               clk,
    input  logic               rst_n,
    // Allocate
    input  logic               alloc_valid,
    input  lsu_pkg::rob_idx_t  alloc_rob_idx,
    input  lsu_pkg::mem_size_e alloc_size,
    output logic               alloc_ready,
    // Store execute
    input  logic               exe_st_valid,
    input  lsu_pkg::rob_idx_t  exe_st_rob_idx,
    input  lsu_pkg::word_t     exe_st_base,
    input  lsu_pkg::word_t     exe_st_imm,
    input  lsu_pkg::word_t     exe_st_data,
    // Commit
    input  logic               commit_valid,
    input  lsu_pkg::rob_idx_t  commit_rob_idx,
    // Load request
    input  logic               ld_valid,
    output logic               ld_ready,
    input  lsu_pkg::rob_idx_t  ld_rob_idx,
    input  lsu_pkg::prd_t      ld_prd,
    input  lsu_pkg::word_t     ld_base,
    input  lsu_pkg::word_t     ld_imm,
    input  lsu_pkg::mem_size_e ld_size,
    input  logic               ld_unsigned,
    // Memory store port
    output logic               mem_st_valid,
    input  logic               mem_st_ready,
    output lsu_pkg::word_t     mem_st_addr,
    output lsu_pkg::word_t     mem_st_data,
    output lsu_pkg::strb_t     mem_st_strb,
    // Memory load port
    output logic               mem_ld_valid,
    input  logic               mem_ld_ready,
    output lsu_pkg::word_t     mem_ld_addr,
    input  logic               mem_ld_resp_valid,
    input  lsu_pkg::word_t     mem_ld_resp_data,
    // Writeback
    output logic               wb_valid,
    input  logic               wb_ready,
    output lsu_pkg::rob_idx_t  wb_rob_idx,
    output lsu_pkg::prd_t      wb_prd,
    output lsu_pkg::word_t     wb_data
);
    import lsu_pkg::*;

    logic     sq_valid    [SQ_DEPTH];
    logic     sq_addr_rdy [SQ_DEPTH];
    rob_idx_t sq_rob_idx  [SQ_DEPTH];
    word_t    sq_addr     [SQ_DEPTH];
    word_t    sq_data     [SQ_DEPTH];
    strb_t    sq_strb     [SQ_DEPTH];
    sq_idx_t  sq_head;

    word_t ld_addr;
    logic  fwd_stall;
    logic  fwd_hit;
    word_t fwd_data;

    store_queue u_store_queue (
        .clk            (clk),
        .rst_n          (rst_n),
        .alloc_valid    (alloc_valid),
        .alloc_rob_idx  (alloc_rob_idx),
        .alloc_size     (alloc_size),
        .alloc_ready    (alloc_ready),
        .exe_st_valid   (exe_st_valid),
        .exe_st_rob_idx (exe_st_rob_idx),
        .exe_st_base    (exe_st_base),
        .exe_st_imm     (exe_st_imm),
        .exe_st_data    (exe_st_data),
        .commit_valid   (commit_valid),
        .commit_rob_idx (commit_rob_idx),
        .mem_st_valid   (mem_st_valid),
        .mem_st_ready   (mem_st_ready),
        .mem_st_addr    (mem_st_addr),
        .mem_st_data    (mem_st_data),
        .mem_st_strb    (mem_st_strb),
        .sq_valid       (sq_valid),
        .sq_addr_rdy    (sq_addr_rdy),
        .sq_rob_idx     (sq_rob_idx),
        .sq_addr        (sq_addr),
        .sq_data        (sq_data),
        .sq_strb        (sq_strb),
        .sq_head        (sq_head)
    );

    store_forward u_store_forward (
        .sq_valid    (sq_valid),
        .sq_addr_rdy (sq_addr_rdy),
        .sq_rob_idx  (sq_rob_idx),
        .sq_addr     (sq_addr),
        .sq_data     (sq_data),
        .sq_strb     (sq_strb),
        .sq_head     (sq_head),
        .ld_rob_idx  (ld_rob_idx),
        .ld_addr     (ld_addr),
        .ld_size     (ld_size),
        .fwd_stall   (fwd_stall),
        .fwd_hit     (fwd_hit),
        .fwd_data    (fwd_data)
    );

    load_pipe u_load_pipe (
        .clk               (clk),
        .rst_n             (rst_n),
        .ld_valid          (ld_valid),
        .ld_ready          (ld_ready),
        .ld_rob_idx        (ld_rob_idx),
        .ld_prd            (ld_prd),
        .ld_base           (ld_base),
        .ld_imm            (ld_imm),
        .ld_size           (ld_size),
        .ld_unsigned       (ld_unsigned),
        .ld_addr           (ld_addr),
        .fwd_stall         (fwd_stall),
        .fwd_hit           (fwd_hit),
        .fwd_data          (fwd_data),
        .mem_ld_valid      (mem_ld_valid),
        .mem_ld_ready      (mem_ld_ready),
        .mem_ld_addr       (mem_ld_addr),
        .mem_ld_resp_valid (mem_ld_resp_valid),
        .mem_ld_resp_data  (mem_ld_resp_data),
        .wb_valid          (wb_valid),
        .wb_ready          (wb_ready),
        .wb_rob_idx        (wb_rob_idx),
        .wb_prd            (wb_prd),
        .wb_data           (wb_data)
    );

endmodule

`default_nettype wire

// ==== test/lsu_properties.sv ====
`default_nettype none

module lsu_properties (
    input logic               clk,
    input logic               rst_n,
    input logic               mem_st_valid,
    input logic               mem_st_ready,
    input lsu_pkg::word_t     mem_st_addr,
    input lsu_pkg::word_t     mem_st_data,
    input lsu_pkg::strb_t     mem_st_strb,
    input logic               mem_ld_valid,
    input logic               mem_ld_ready,
    input lsu_pkg::word_t     mem_ld_addr,
    input logic               wb_valid,
    input logic               wb_ready,
    input lsu_pkg::rob_idx_t  wb_rob_idx,
    input lsu_pkg::prd_t      wb_prd,
    input lsu_pkg::word_t     wb_data,
    input logic               alloc_ready,
    input logic               sq_valid [lsu_pkg::SQ_DEPTH]
);
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    a_st_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_st_valid && !mem_st_ready |=> mem_st_valid && $stable(mem_st_addr)
            && $stable(mem_st_data) && $stable(mem_st_strb))
        else $error("store request dropped or changed before mem_st_ready");

    a_ld_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ld_valid && !mem_ld_ready |=> mem_ld_valid && $stable(mem_ld_addr))
        else $error("load request dropped or changed before mem_ld_ready");

    a_wb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid && !wb_ready |=> wb_valid && $stable(wb_rob_idx)
            && $stable(wb_prd) && $stable(wb_data))
        else $error("writeback dropped or changed before wb_ready");

    a_full: assert property (@(posedge clk) disable iff (!rst_n)
        !(alloc_ready && sq_valid[0] && sq_valid[1] && sq_valid[2] && sq_valid[3]))
        else $error("alloc_ready high with all store queue entries valid");

endmodule

bind lsu_top lsu_properties u_props (.*);

`default_nettype wire

// ==== test/lsu_tb.sv ====
`default_nettype none

module lsu_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import lsu_pkg::*;

    localparam int K_ALLOC  = 0;
    localparam int K_EXEC   = 1;
    localparam int K_COMMIT = 2;
    localparam int K_LOAD   = 3;
    localparam int K_LOADNW = 4;
    localparam int K_SYNC   = 5;
    localparam int K_READY  = 6;

    typedef struct {
        string     name;
        int        kind;
        int        rob;
        word_t     base;
        word_t     imm;
        mem_size_e size;
        logic      uns;
        word_t     data;
    } step_t;

    typedef struct {
        string    name;
        rob_idx_t rob;
        prd_t     prd;
        word_t    data;
    } exp_t;

    logic clk = 1'b0;
    logic rst_n;
    logic alloc_valid, alloc_ready, exe_st_valid, commit_valid;
    rob_idx_t alloc_rob_idx, exe_st_rob_idx, commit_rob_idx, ld_rob_idx, wb_rob_idx;
    mem_size_e alloc_size, ld_size;
    word_t exe_st_base, exe_st_imm, exe_st_data, ld_base, ld_imm;
    logic ld_valid, ld_ready, ld_unsigned;
    prd_t ld_prd, wb_prd;
    logic mem_st_valid, mem_st_ready, mem_ld_valid, mem_ld_ready, mem_ld_resp_valid;
    word_t mem_st_addr, mem_st_data, mem_ld_addr, mem_ld_resp_data, wb_data;
    strb_t mem_st_strb;
    logic wb_valid, wb_ready;

    step_t steps[$];
    int    ldq[$];
    exp_t  expq[$];
    word_t mem [1024];
    logic [15:0] lfsr = 16'd46429;
    int pending, allocs, drains, errors, tests, cycles, limit, resp_wait;
    word_t resp_addr;

    lsu_top uut (.*);

    always #20 clk = ~clk;

    // Galois LFSR stepped once per random bit
    function automatic logic next_bit();
        lfsr = lfsr[0] ? ((lfsr >> 1) ^ 16'hB400) : (lfsr >> 1);
        return lfsr[0];
    endfunction

    function automatic word_t fill_word(int idx);
        return (32'h9E3779B9 * (idx + 1)) ^ idx;
    endfunction

    // Program-order image of a word with stores older than rob_limit applied
    function automatic word_t model_word(word_t addr, int rob_limit);
        word_t w;
        word_t a;
        word_t al;
        strb_t m;
        w = fill_word(int'(addr[11:2]));
        foreach (steps[i]) begin
            a = steps[i].base + steps[i].imm;
            if (steps[i].kind == K_EXEC && steps[i].rob < rob_limit
                    && a[31:2] == addr[31:2]) begin
                m  = byte_mask(steps[i].size, a[1:0]);
                al = lane_align(steps[i].data, steps[i].size, a[1:0]);
                for (int k = 0; k < 4; k++) begin
                    if (m[k]) w[8*k +: 8] = al[8*k +: 8];
                end
            end
        end
        return w;
    endfunction

    function automatic word_t extend(word_t w, logic [1:0] lo, mem_size_e sz, logic uns);
        word_t s;
        case (sz)
            MSZ_B: begin
                s = w >> (8 * lo);
                return uns ? {24'b0, s[7:0]} : {{24{s[7]}}, s[7:0]};
            end
            MSZ_H: begin
                s = w >> (16 * lo[1]);
                return uns ? {16'b0, s[15:0]} : {{16{s[15]}}, s[15:0]};
            end
            default: return w;
        endcase
    endfunction

    task automatic add_step(string name, int kind, int rob, word_t base, word_t imm,
                            mem_size_e size, logic uns, word_t data);
        step_t s;
        s = '{name, kind, rob, base, imm, size, uns, data};
        steps.push_back(s);
    endtask

    // ====================
    // Memory model and back-pressure
    // ====================
    always @(posedge clk) begin
        if (rst_n && mem_st_valid && mem_st_ready) begin
            for (int k = 0; k < 4; k++) begin
                if (mem_st_strb[k]) mem[mem_st_addr[11:2]][8*k +: 8] = mem_st_data[8*k +: 8];
            end
            drains++;
        end
        if (rst_n && mem_ld_valid && mem_ld_ready) begin
            resp_addr = mem_ld_addr;
            resp_wait = 1 + {next_bit(), next_bit()};
        end
        #2;
        mem_ld_resp_valid = 1'b0;
        if (resp_wait > 0) begin
            resp_wait--;
            if (resp_wait == 0) begin
                mem_ld_resp_valid = 1'b1;
                mem_ld_resp_data  = mem[resp_addr[11:2]];
            end
        end
        wb_ready     = next_bit() | next_bit();
        mem_st_ready = next_bit() | next_bit();
        mem_ld_ready = next_bit() | next_bit();
    end

    // Writeback checker for loads completing in acceptance order
    always @(posedge clk) begin : wb_check
        exp_t e;
        logic ok;
        if (rst_n && wb_valid && wb_ready) begin
            assert (expq.size() != 0) else begin
                $display("Writeback seen with no load outstanding");
                errors++;
            end
            if (expq.size() != 0) begin
                e  = expq.pop_front();
                ok = 1'b1;
                tests++;
                assert (wb_data == e.data) else begin
                    $display("Fail %s expected %h actual %h", e.name, e.data, wb_data);
                    errors++;
                    ok = 1'b0;
                end
                assert (wb_rob_idx == e.rob && wb_prd == e.prd) else begin
                    $display("Fail %s expected rob/prd %0d/%0d actual %0d/%0d", e.name,
                             e.rob, e.prd, wb_rob_idx, wb_prd);
                    errors++;
                    ok = 1'b0;
                end
                if (ok) $display("ok   %s", e.name);
                pending--;
            end
        end
    end

    // Load driver issuing one request at a time
    initial begin : load_driver
        step_t s;
        exp_t  e;
        word_t a;
        ld_valid    = 1'b0;
        ld_rob_idx  = '0;
        ld_prd      = '0;
        ld_base     = '0;
        ld_imm      = '0;
        ld_size     = MSZ_W;
        ld_unsigned = 1'b0;
        forever begin
            @(posedge clk);
            if (rst_n && ldq.size() > 0) begin
                s = steps[ldq.pop_front()];
                a = s.base + s.imm;
                #2;
                ld_valid    = 1'b1;
                ld_rob_idx  = rob_idx_t'(s.rob);
                ld_prd      = prd_t'(s.rob + 32);
                ld_base     = s.base;
                ld_imm      = s.imm;
                ld_size     = s.size;
                ld_unsigned = s.uns;
                do @(posedge clk); while (!ld_ready);
                e = '{s.name, rob_idx_t'(s.rob), prd_t'(s.rob + 32),
                      extend(model_word(a, s.rob), a[1:0], s.size, s.uns)};
                expq.push_back(e);
                #2 ld_valid = 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (limit > 0 && cycles >= limit) begin
            $display("Timeout after %0d cycles, the DUT stopped making progress", cycles);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ====================
    // Stimulus table and main loop
    // ====================
    initial begin
        int n;
        word_t a;
        rst_n = 1'b0;
        alloc_valid = 1'b0;
        alloc_rob_idx = '0;
        alloc_size = MSZ_W;
        exe_st_valid = 1'b0;
        exe_st_rob_idx = '0;
        exe_st_base = '0;
        exe_st_imm = '0;
        exe_st_data = '0;
        commit_valid = 1'b0;
        commit_rob_idx = '0;
        mem_st_ready = 1'b0;
        mem_ld_ready = 1'b1;
        mem_ld_resp_valid = 1'b0;
        mem_ld_resp_data = '0;
        wb_ready = 1'b0;
        for (int i = 0; i < 1024; i++) mem[i] = fill_word(i);

        // Plain memory loads
        add_step("ld_w_mem",   K_LOAD, 1, 32'h40, 0, MSZ_W, 0, 0);
        add_step("ld_b_sign",  K_LOAD, 2, 32'h44, 1, MSZ_B, 0, 0);
        add_step("ld_bu_mem",  K_LOAD, 3, 32'h48, 3, MSZ_B, 1, 0);
        add_step("ld_h_sign",  K_LOAD, 4, 32'h4C, 0, MSZ_H, 0, 0);
        add_step("ld_hu_mem",  K_LOAD, 5, 32'h50, 2, MSZ_H, 1, 0);
        // Committed stores of each size and a load they partly cover
        add_step("al6", K_ALLOC, 6, 0, 0, MSZ_W, 0, 0);
        add_step("al7", K_ALLOC, 7, 0, 0, MSZ_B, 0, 0);
        add_step("al8", K_ALLOC, 8, 0, 0, MSZ_H, 0, 0);
        add_step("ex6", K_EXEC, 6, 32'h100, 0, MSZ_W, 0, 32'hCAFEF00D);
        add_step("ex7", K_EXEC, 7, 32'h100, 5, MSZ_B, 0, 32'h77);
        add_step("ex8", K_EXEC, 8, 32'h108, 2, MSZ_H, 0, 32'h8001);
        add_step("cm6", K_COMMIT, 6, 0, 0, MSZ_W, 0, 0);
        add_step("cm7", K_COMMIT, 7, 0, 0, MSZ_W, 0, 0);
        add_step("cm8", K_COMMIT, 8, 0, 0, MSZ_W, 0, 0);
        add_step("ld_w_partial", K_LOAD, 9, 32'h104, 0, MSZ_W, 1, 0);
        // Forwarding from uncommitted stores where the youngest wins
        add_step("al10", K_ALLOC, 10, 0, 0, MSZ_W, 0, 0);
        add_step("ex10", K_EXEC, 10, 32'h200, 0, MSZ_W, 0, 32'h11223344);
        add_step("al11", K_ALLOC, 11, 0, 0, MSZ_H, 0, 0);
        add_step("ex11", K_EXEC, 11, 32'h200, 2, MSZ_H, 0, 32'hAAAABEEF);
        add_step("ld_h_fwd_young", K_LOAD, 12, 32'h200, 2, MSZ_H, 0, 0);
        add_step("ld_bu_fwd_old",  K_LOAD, 13, 32'h201, 0, MSZ_B, 1, 0);
        add_step("cm10", K_COMMIT, 10, 0, 0, MSZ_W, 0, 0);
        add_step("cm11", K_COMMIT, 11, 0, 0, MSZ_W, 0, 0);
        // Load waiting on a missing address and then on a partial cover
        add_step("al14", K_ALLOC, 14, 0, 0, MSZ_B, 0, 0);
        add_step("ld_w_stalled", K_LOADNW, 15, 32'h300, 0, MSZ_W, 0, 0);
        add_step("ex14", K_EXEC, 14, 32'h300, 1, MSZ_B, 0, 32'h5A);
        add_step("cm14", K_COMMIT, 14, 0, 0, MSZ_W, 0, 0);
        add_step("sync", K_SYNC, 0, 0, 0, MSZ_W, 0, 0);
        // Full queue
        for (int r = 16; r < 20; r++) add_step("al", K_ALLOC, r, 0, 0, MSZ_W, 0, 0);
        add_step("queue_full", K_READY, 0, 0, 0, MSZ_W, 0, 0);
        add_step("ex16", K_EXEC, 16, 32'h400, 0, MSZ_W, 0, 32'h0BADBEEF);
        add_step("cm16", K_COMMIT, 16, 0, 0, MSZ_W, 0, 0);
        add_step("slot_freed", K_READY, 0, 0, 0, MSZ_W, 0, 1);
        for (int r = 17; r < 20; r++) begin
            add_step("ex", K_EXEC, r, 32'h400, 4 * (r - 16), MSZ_W, 0, 32'h01010101 * r);
            add_step("cm", K_COMMIT, r, 0, 0, MSZ_W, 0, 0);
        end
        add_step("ld_hu_after_full", K_LOAD, 20, 32'h406, 0, MSZ_H, 1, 0);
        limit = 60 * steps.size() + 200;

        repeat (4) @(posedge clk);
        #2 rst_n = 1'b1;

        foreach (steps[i]) begin
            @(posedge clk);
            #2;
            case (steps[i].kind)
                K_ALLOC: begin
                    alloc_valid   = 1'b1;
                    alloc_rob_idx = rob_idx_t'(steps[i].rob);
                    alloc_size    = steps[i].size;
                    do @(posedge clk); while (!alloc_ready);
                    allocs++;
                    #2 alloc_valid = 1'b0;
                end
                K_EXEC: begin
                    exe_st_valid   = 1'b1;
                    exe_st_rob_idx = rob_idx_t'(steps[i].rob);
                    exe_st_base    = steps[i].base;
                    exe_st_imm     = steps[i].imm;
                    exe_st_data    = steps[i].data;
                    @(posedge clk);
                    #2 exe_st_valid = 1'b0;
                end
                K_COMMIT: begin
                    commit_valid   = 1'b1;
                    commit_rob_idx = rob_idx_t'(steps[i].rob);
                    @(posedge clk);
                    #2 commit_valid = 1'b0;
                end
                K_LOAD, K_LOADNW: begin
                    ldq.push_back(i);
                    pending++;
                    if (steps[i].kind == K_LOAD) begin
                        while (pending > 0) @(posedge clk);
                    end
                end
                K_SYNC: while (pending > 0) @(posedge clk);
                K_READY: begin
                    n = 0;
                    while (alloc_ready !== steps[i].data[0] && n < 20) begin
                        @(posedge clk);
                        #2 n++;
                    end
                    tests++;
                    assert (alloc_ready === steps[i].data[0]) else begin
                        $display("Fail %s expected %b actual %b", steps[i].name,
                                 steps[i].data[0], alloc_ready);
                        errors++;
                    end
                    if (alloc_ready === steps[i].data[0]) $display("ok   %s", steps[i].name);
                end
                default: ;
            endcase
        end

        // Final drain and memory against the program-order image
        while (pending > 0 || drains < allocs) @(posedge clk);
        foreach (steps[i]) begin
            a = steps[i].base + steps[i].imm;
            if (steps[i].kind == K_EXEC) begin
                tests++;
                assert (mem[a[11:2]] == model_word(a, 32)) else begin
                    $display("Fail mem_%h expected %h actual %h", {a[31:2], 2'b00},
                             model_word(a, 32), mem[a[11:2]]);
                    errors++;
                end
                if (mem[a[11:2]] == model_word(a, 32)) $display("ok   mem_%h", a);
            end
        end

        $display("Tests %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/lsu_pkg.sv
hdl/store_queue.sv
hdl/store_forward.sv
hdl/load_align.sv
hdl/load_pipe.sv
hdl/lsu_top.sv
test/lsu_properties.sv
test/lsu_tb.sv
